// File: hw/vga_grid_pkg.sv
package vga_grid_pkg;

  // Screen coordinate, column or row
  typedef logic [9:0] pixel_coord_t;

  // Playfield row index, 0 to 19
  typedef logic [4:0] cell_row_t;

  // Playfield column index, 0 to 9
  typedef logic [3:0] cell_col_t;

  // Color as {red, green, blue}
  typedef logic [2:0] color_t;

  // Playfield size, fixed by the game
  localparam int GRID_ROWS = 20;
  localparam int GRID_COLS = 10;

  // Empty cell and background
  localparam color_t COLOR_BLACK = 3'b000;

  // Grid lines
  localparam color_t COLOR_WHITE = 3'b111;

endpackage

// File: hw/vga_timing.sv
`timescale 1ns/1ps

module vga_timing
  import vga_grid_pkg::*;
(
  input  logic         clk,
  input  logic         arst_n,
  output pixel_coord_t pixel_x,
  output pixel_coord_t pixel_y,
  output logic         active,
  output logic         hsync_n,
  output logic         vsync_n
);

  // Horizontal timing in pixels, 640x480 mode
  localparam int H_ACTIVE = 640;
  localparam int H_FP     = 16;
  localparam int H_SYNC   = 96;
  localparam int H_BP     = 48;
  localparam int H_TOTAL  = H_ACTIVE + H_FP + H_SYNC + H_BP;

  // Vertical timing in lines
  localparam int V_ACTIVE = 480;
  localparam int V_FP     = 10;
  localparam int V_SYNC   = 2;
  localparam int V_BP     = 33;
  localparam int V_TOTAL  = V_ACTIVE + V_FP + V_SYNC + V_BP;

  // Counter limits and sync windows as coordinates
  localparam pixel_coord_t H_ACT_END    = pixel_coord_t'(H_ACTIVE);
  localparam pixel_coord_t H_SYNC_START = pixel_coord_t'(H_ACTIVE + H_FP);
  localparam pixel_coord_t H_SYNC_END   = pixel_coord_t'(H_ACTIVE + H_FP + H_SYNC);
  localparam pixel_coord_t H_LAST       = pixel_coord_t'(H_TOTAL - 1);
  localparam pixel_coord_t V_ACT_END    = pixel_coord_t'(V_ACTIVE);
  localparam pixel_coord_t V_SYNC_START = pixel_coord_t'(V_ACTIVE + V_FP);
  localparam pixel_coord_t V_SYNC_END   = pixel_coord_t'(V_ACTIVE + V_FP + V_SYNC);
  localparam pixel_coord_t V_LAST       = pixel_coord_t'(V_TOTAL - 1);

  pixel_coord_t h_next;
  pixel_coord_t v_next;
  logic         h_wrap;

  // Next position, one pixel per clock
  always_comb begin
    h_wrap = (pixel_x == H_LAST);
    h_next = h_wrap ? '0 : pixel_x + 10'd1;
    v_next = pixel_y;
    // Line done, step to next row
    if (h_wrap) begin
      v_next = (pixel_y == V_LAST) ? '0 : pixel_y + 10'd1;
    end
  end

  // Syncs and active flag decoded from the next position,
  // so all outputs describe the same pixel
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pixel_x <= '0;
      pixel_y <= '0;
      // Pixel (0,0) is visible
      active  <= 1'b1;
      hsync_n <= 1'b1;
      vsync_n <= 1'b1;
    end else begin
      pixel_x <= h_next;
      pixel_y <= v_next;
      active  <= (h_next < H_ACT_END) && (v_next < V_ACT_END);
      hsync_n <= !((h_next >= H_SYNC_START) && (h_next < H_SYNC_END));
      vsync_n <= !((v_next >= V_SYNC_START) && (v_next < V_SYNC_END));
    end
  end

endmodule

// File: hw/playfield_ram.sv
`timescale 1ns/1ps

module playfield_ram
  import vga_grid_pkg::*;
(
  input  logic      clk,
  input  logic      arst_n,
  input  logic      cell_we,
  input  cell_row_t cell_row,
  input  cell_col_t cell_col,
  input  color_t    cell_color,
  input  logic      field_clear,
  input  cell_row_t rd_row,
  input  cell_col_t rd_col,
  output color_t    rd_color
);

  // One color per playfield cell
  color_t cells [GRID_ROWS][GRID_COLS];

  logic wr_in_range;
  logic rd_in_range;

  // Addresses past the field are dropped
  assign wr_in_range = (int'(cell_row) < GRID_ROWS) && (int'(cell_col) < GRID_COLS);
  assign rd_in_range = (int'(rd_row) < GRID_ROWS) && (int'(rd_col) < GRID_COLS);

  // Clear wins over a write in the same cycle
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int r = 0; r < GRID_ROWS; r++) begin
        for (int c = 0; c < GRID_COLS; c++) begin
          cells[r][c] <= COLOR_BLACK;
        end
      end
    end else if (field_clear) begin
      for (int r = 0; r < GRID_ROWS; r++) begin
        for (int c = 0; c < GRID_COLS; c++) begin
          cells[r][c] <= COLOR_BLACK;
        end
      end
    end else if (cell_we && wr_in_range) begin
      cells[cell_row][cell_col] <= cell_color;
    end
  end

  // Registered read, black outside the field
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rd_color <= COLOR_BLACK;
    end else begin
      rd_color <= rd_in_range ? cells[rd_row][rd_col] : COLOR_BLACK;
    end
  end

endmodule

// File: hw/grid_renderer.sv
`timescale 1ns/1ps

module grid_renderer
  import vga_grid_pkg::*;
#(
  parameter int GRID_X0    = 245,
  parameter int GRID_Y0    = 90,
  parameter int BLOCK_SIZE = 15
) (
  input  logic         clk,
  input  logic         arst_n,
  input  pixel_coord_t pixel_x,
  input  pixel_coord_t pixel_y,
  input  logic         active,
  input  logic         hsync_n,
  input  logic         vsync_n,
  output cell_row_t    rd_row,
  output cell_col_t    rd_col,
  input  color_t       rd_color,
  output logic         red,
  output logic         green,
  output logic         blue,
  output logic         hsync_out_n,
  output logic         vsync_out_n
);

  // Grid window bounds in screen coordinates
  localparam pixel_coord_t X0    = pixel_coord_t'(GRID_X0);
  localparam pixel_coord_t Y0    = pixel_coord_t'(GRID_Y0);
  localparam pixel_coord_t X_END = pixel_coord_t'(GRID_X0 + GRID_COLS * BLOCK_SIZE);
  localparam pixel_coord_t Y_END = pixel_coord_t'(GRID_Y0 + GRID_ROWS * BLOCK_SIZE);
  localparam pixel_coord_t BLK   = pixel_coord_t'(BLOCK_SIZE);

  pixel_coord_t dx;
  pixel_coord_t dy;
  pixel_coord_t col_idx;
  pixel_coord_t row_idx;
  logic         in_grid;
  logic         on_line;

  // Stage 1 registers
  logic s1_in_grid;
  logic s1_on_line;
  logic s1_active;
  logic s1_hsync_n;
  logic s1_vsync_n;

  // Stage 2 registers
  logic s2_in_grid;
  logic s2_on_line;
  logic s2_active;
  logic s2_hsync_n;
  logic s2_vsync_n;

  color_t pix_color;

  // Offset from grid origin, wraps left of or above the grid
  always_comb begin
    dx      = pixel_x - X0;
    dy      = pixel_y - Y0;
    col_idx = dx / BLK;
    row_idx = dy / BLK;
    in_grid = (pixel_x >= X0) && (pixel_x < X_END) &&
              (pixel_y >= Y0) && (pixel_y < Y_END);
    // Block edges plus the closing right and bottom lines
    on_line = ((dx % BLK) == '0) || ((dy % BLK) == '0) ||
              (pixel_x == X_END - 10'd1) || (pixel_y == Y_END - 10'd1);
  end

  // Stage 1, cell index goes straight to the RAM read port
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      s1_in_grid <= 1'b0;
      s1_on_line <= 1'b0;
      s1_active  <= 1'b0;
      s1_hsync_n <= 1'b1;
      s1_vsync_n <= 1'b1;
      rd_row     <= '0;
      rd_col     <= '0;
    end else begin
      s1_in_grid <= in_grid;
      s1_on_line <= on_line;
      s1_active  <= active;
      s1_hsync_n <= hsync_n;
      s1_vsync_n <= vsync_n;
      rd_row     <= cell_row_t'(row_idx);
      rd_col     <= cell_col_t'(col_idx);
    end
  end

  // Stage 2, lines up with the registered cell color
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      s2_in_grid <= 1'b0;
      s2_on_line <= 1'b0;
      s2_active  <= 1'b0;
      s2_hsync_n <= 1'b1;
      s2_vsync_n <= 1'b1;
    end else begin
      s2_in_grid <= s1_in_grid;
      s2_on_line <= s1_on_line;
      s2_active  <= s1_active;
      s2_hsync_n <= s1_hsync_n;
      s2_vsync_n <= s1_vsync_n;
    end
  end

  // Final color select
  always_comb begin
    if (!s2_active || !s2_in_grid) begin
      pix_color = COLOR_BLACK;
    end else if (s2_on_line) begin
      pix_color = COLOR_WHITE;
    end else begin
      pix_color = rd_color;
    end
  end

  // Color bits, red on top
  assign red   = pix_color[2];
  assign green = pix_color[1];
  assign blue  = pix_color[0];

  // Syncs two stages late, same as color
  assign hsync_out_n = s2_hsync_n;
  assign vsync_out_n = s2_vsync_n;

endmodule

// File: hw/vga_grid_top.sv
`timescale 1ns/1ps

module vga_grid_top
  import vga_grid_pkg::*;
#(
  parameter int GRID_X0    = 245,
  parameter int GRID_Y0    = 90,
  parameter int BLOCK_SIZE = 15
) (
  input  logic      clk,
  input  logic      arst_n,
  input  logic      cell_we,
  input  cell_row_t cell_row,
  input  cell_col_t cell_col,
  input  color_t    cell_color,
  input  logic      field_clear,
  output logic      red,
  output logic      green,
  output logic      blue,
  output logic      hsync_n,
  output logic      vsync_n
);

  // Timing to renderer
  pixel_coord_t pixel_x;
  pixel_coord_t pixel_y;
  logic         active;
  logic         tim_hsync_n;
  logic         tim_vsync_n;

  // Renderer read port
  cell_row_t rd_row;
  cell_col_t rd_col;
  color_t    rd_color;

  // Pixel counters and raw syncs
  vga_timing u_timing (
    .clk     (clk),
    .arst_n  (arst_n),
    .pixel_x (pixel_x),
    .pixel_y (pixel_y),
    .active  (active),
    .hsync_n (tim_hsync_n),
    .vsync_n (tim_vsync_n)
  );

  // Two-stage pixel pipeline
  grid_renderer #(
    .GRID_X0    (GRID_X0),
    .GRID_Y0    (GRID_Y0),
    .BLOCK_SIZE (BLOCK_SIZE)
  ) u_renderer (
    .clk         (clk),
    .arst_n      (arst_n),
    .pixel_x     (pixel_x),
    .pixel_y     (pixel_y),
    .active      (active),
    .hsync_n     (tim_hsync_n),
    .vsync_n     (tim_vsync_n),
    .rd_row      (rd_row),
    .rd_col      (rd_col),
    .rd_color    (rd_color),
    .red         (red),
    .green       (green),
    .blue        (blue),
    .hsync_out_n (hsync_n),
    .vsync_out_n (vsync_n)
  );

  // Cell storage
  playfield_ram u_playfield (
    .clk         (clk),
    .arst_n      (arst_n),
    .cell_we     (cell_we),
    .cell_row    (cell_row),
    .cell_col    (cell_col),
    .cell_color  (cell_color),
    .field_clear (field_clear),
    .rd_row      (rd_row),
    .rd_col      (rd_col),
    .rd_color    (rd_color)
  );

endmodule

// File: test/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
  output logic clk,
  output logic arst_n
);

  // 100 MHz, one pixel per cycle
  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Reset held over two rising edges
  initial begin
    arst_n = 1'b0;
    repeat (2) @(posedge clk);
    #1;
    arst_n = 1'b1;
  end

endmodule

// File: test/vga_grid_checker.sv
`timescale 1ns/1ps

module vga_grid_checker
  import vga_grid_pkg::*;
#(
  parameter int GRID_X0    = 245,
  parameter int GRID_Y0    = 90,
  parameter int BLOCK_SIZE = 15
) (
  input logic      clk,
  input logic      arst_n,
  input logic      cell_we,
  input cell_row_t cell_row,
  input cell_col_t cell_col,
  input color_t    cell_color,
  input logic      field_clear,
  input logic      red,
  input logic      green,
  input logic      blue,
  input logic      hsync_n,
  input logic      vsync_n
);

  // 640x480 frame in pixels and lines
  localparam int H_TOTAL  = 800;
  localparam int H_SYNC0  = 656;
  localparam int V_TOTAL  = 525;
  localparam int V_SYNC0  = 490;
  localparam int GRID_W   = GRID_COLS * BLOCK_SIZE;
  localparam int GRID_H   = GRID_ROWS * BLOCK_SIZE;

  // Expected content of every cell
  color_t shadow [GRID_ROWS][GRID_COLS];

  // Position of the pixel now on the outputs
  int     x_reg;
  int     y_reg;
  int     x_pred;
  int     y_pred;
  int     x_cur;
  int     y_cur;
  int     dx;
  int     dy;

  // Frames left before interior pixels are trusted
  int     stale_frames;

  logic   h_prev;
  logic   v_prev;
  logic   h_fell;
  logic   v_fell;
  logic   exp_hsync_n;
  logic   exp_vsync_n;
  logic   interior;
  color_t pix;
  color_t exp_color;
  logic   failed = 1'b0;

  always_comb begin
    pix    = {red, green, blue};
    h_fell = h_prev && !hsync_n;
    v_fell = v_prev && !vsync_n;
    x_pred = (x_reg == H_TOTAL - 1) ? 0 : x_reg + 1;
    // Falling hsync pins the column
    x_cur  = h_fell ? H_SYNC0 : x_pred;
    y_pred = y_reg;
    if (x_cur == 0) begin
      y_pred = (y_reg == V_TOTAL - 1) ? 0 : y_reg + 1;
    end
    // Falling vsync pins the row
    y_cur  = v_fell ? V_SYNC0 : y_pred;
    exp_hsync_n = !(x_cur >= H_SYNC0 && x_cur < H_SYNC0 + 96);
    exp_vsync_n = !(y_cur >= V_SYNC0 && y_cur < V_SYNC0 + 2);
    dx = x_cur - GRID_X0;
    dy = y_cur - GRID_Y0;
    interior  = 1'b0;
    exp_color = COLOR_BLACK;
    // Window sits inside the visible area
    if (dx >= 0 && dx < GRID_W && dy >= 0 && dy < GRID_H) begin
      // Block edges plus the closing right and bottom lines
      if (dx % BLOCK_SIZE == 0 || dy % BLOCK_SIZE == 0 ||
          dx == GRID_W - 1 || dy == GRID_H - 1) begin
        exp_color = COLOR_WHITE;
      end else begin
        interior  = 1'b1;
        exp_color = shadow[5'(dy / BLOCK_SIZE)][4'(dx / BLOCK_SIZE)];
      end
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      // Pixel (0,0) reaches the outputs on the third edge
      x_reg        <= H_TOTAL - 3;
      y_reg        <= V_TOTAL - 1;
      h_prev       <= 1'b1;
      v_prev       <= 1'b1;
      stale_frames <= 0;
      for (int r = 0; r < GRID_ROWS; r++) begin
        for (int c = 0; c < GRID_COLS; c++) begin
          shadow[r][c] <= COLOR_BLACK;
        end
      end
    end else begin
      x_reg  <= x_cur;
      y_reg  <= y_cur;
      h_prev <= hsync_n;
      v_prev <= vsync_n;
      // One frame fewer to wait at each frame start
      if (x_cur == 0 && y_cur == 0 && stale_frames != 0) begin
        stale_frames <= stale_frames - 1;
      end
      // Clear beats a write in the same cycle
      if (field_clear) begin
        for (int r = 0; r < GRID_ROWS; r++) begin
          for (int c = 0; c < GRID_COLS; c++) begin
            shadow[r][c] <= COLOR_BLACK;
          end
        end
        stale_frames <= 2;
      end else if (cell_we && int'(cell_row) < GRID_ROWS && int'(cell_col) < GRID_COLS) begin
        shadow[cell_row][cell_col] <= cell_color;
        stale_frames <= 2;
      end
    end
  end

  a_hsync: assert property (@(posedge clk) disable iff (!arst_n) hsync_n == exp_hsync_n)
    else begin
      failed = 1'b1;
      $error("MISMATCH hsync_n: got %h, expected %h", $sampled(hsync_n), $sampled(exp_hsync_n));
    end

  a_vsync: assert property (@(posedge clk) disable iff (!arst_n) vsync_n == exp_vsync_n)
    else begin
      failed = 1'b1;
      $error("MISMATCH vsync_n: got %h, expected %h", $sampled(vsync_n), $sampled(exp_vsync_n));
    end

  // Sync edges must land where the running count says
  a_period: assert property (@(posedge clk) disable iff (!arst_n)
    (!h_fell || x_pred == H_SYNC0) && (!v_fell || (y_pred == V_SYNC0 && x_cur == 0)))
    else begin
      failed = 1'b1;
      $error("A sync pulse started away from its 800 by 525 frame period");
    end

  // Cells still settling after an update are skipped
  a_color: assert property (@(posedge clk) disable iff (!arst_n)
    !(interior && stale_frames != 0) |-> pix == exp_color)
    else begin
      failed = 1'b1;
      $error("MISMATCH red/green/blue: got %h, expected %h at x %0d y %0d",
             $sampled(pix), $sampled(exp_color), $sampled(x_cur), $sampled(y_cur));
    end

endmodule

// File: test/tb_vga_grid.sv
`timescale 1ns/1ps

module tb_vga_grid
  import vga_grid_pkg::*;
();

  // One frame is 800 x 525 clocks of 10 ns
  localparam int FRAME_NS    = 800 * 525 * 10;
  localparam int RUN_FRAMES  = 5;
  localparam int WATCHDOG_NS = (RUN_FRAMES + 1) * FRAME_NS;

  logic      clk;
  logic      arst_n;
  logic      cell_we;
  cell_row_t cell_row;
  cell_col_t cell_col;
  color_t    cell_color;
  logic      field_clear;
  logic      red;
  logic      green;
  logic      blue;
  logic      hsync_n;
  logic      vsync_n;
  int        seed;

  tb_clock u_clock (
    .clk    (clk),
    .arst_n (arst_n)
  );

  vga_grid_top #(
    .GRID_X0    (245),
    .GRID_Y0    (90),
    .BLOCK_SIZE (15)
  ) u_dut (
    .clk         (clk),
    .arst_n      (arst_n),
    .cell_we     (cell_we),
    .cell_row    (cell_row),
    .cell_col    (cell_col),
    .cell_color  (cell_color),
    .field_clear (field_clear),
    .red         (red),
    .green       (green),
    .blue        (blue),
    .hsync_n     (hsync_n),
    .vsync_n     (vsync_n)
  );

  bind vga_grid_top vga_grid_checker #(
    .GRID_X0    (GRID_X0),
    .GRID_Y0    (GRID_Y0),
    .BLOCK_SIZE (BLOCK_SIZE)
  ) u_checker (
    .clk         (clk),
    .arst_n      (arst_n),
    .cell_we     (cell_we),
    .cell_row    (cell_row),
    .cell_col    (cell_col),
    .cell_color  (cell_color),
    .field_clear (field_clear),
    .red         (red),
    .green       (green),
    .blue        (blue),
    .hsync_n     (hsync_n),
    .vsync_n     (vsync_n)
  );

  task automatic abort_run(input string why);
    $display("FAIL: see errors above");
    $fatal(1, "%s", why);
  endtask

  // Back-to-back writes, many rows and columns past the field
  task automatic random_writes(input int count);
    logic [31:0] rnd;
    for (int i = 0; i < count; i++) begin
      rnd = $random(seed);
      @(posedge clk);
      #1;
      cell_we    = 1'b1;
      cell_row   = rnd[4:0];
      cell_col   = rnd[8:5];
      cell_color = rnd[11:9];
    end
    @(posedge clk);
    #1;
    cell_we = 1'b0;
  endtask

  // Write in the clear cycle must lose
  task automatic clear_field();
    @(posedge clk);
    #1;
    field_clear = 1'b1;
    cell_we     = 1'b1;
    cell_row    = 5'd3;
    cell_col    = 4'd4;
    cell_color  = 3'b101;
    @(posedge clk);
    #1;
    field_clear = 1'b0;
    cell_we     = 1'b0;
  endtask

  // First failed assertion ends the run
  always @(posedge clk) begin
    if (u_dut.u_checker.failed) begin
      abort_run("A checker assertion failed");
    end
  end

  initial begin
    #(WATCHDOG_NS);
    abort_run("Watchdog expired before the run finished");
  end

  initial begin
    seed        = 32'he17a226d;
    cell_we     = 1'b0;
    cell_row    = '0;
    cell_col    = '0;
    cell_color  = COLOR_BLACK;
    field_clear = 1'b0;
    @(posedge arst_n);
    random_writes(150);
    // Frame 2 is the first fully checked one
    repeat (3) @(negedge vsync_n);
    clear_field();
    repeat (2) @(negedge vsync_n);
    @(posedge clk);
    if (u_dut.u_checker.failed) begin
      abort_run("A checker assertion failed at the end of the run");
    end else begin
      $display("PASS: all tests");
      $finish;
    end
  end

endmodule

// File: all.f
hw/vga_grid_pkg.sv
hw/vga_timing.sv
hw/playfield_ram.sv
hw/grid_renderer.sv
hw/vga_grid_top.sv
test/tb_clock.sv
test/vga_grid_checker.sv
test/tb_vga_grid.sv

// File: Makefile
SIM       ?= verilator
SIM_FLAGS ?= --binary --assert --timing --timescale 1ns/1ps -j 0 --Mdir obj_dir
TOP       ?= tb_vga_grid
FILE_LIST ?= all.f
RUN_FLAGS ?= +verilator+error+limit+100
PASS_MSG  := PASS: all tests

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILE_LIST)
	@out=$$(./obj_dir/V$(TOP) $(RUN_FLAGS) 2>&1); echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf obj_dir
